// File: source/in_shift_reg.sv
// ----------------------------------------------------------
// Input shift register with saturating bit counter
// ----------------------------------------------------------
`timescale 1ns/100ps

module in_shift_reg (
  input  logic        clk,
  input  logic        reset,
  input  logic        shift_right,
  input  logic        set,
  input  logic        shift,
  input  logic [4:0]  amount,
  input  logic [31:0] din,
  output logic [31:0] value,
  output logic [5:0]  count
);

  logic [5:0]  n;
  logic [31:0] keep_mask;
  logic [63:0] right_cat;
  logic [31:0] shifted;
  logic [6:0]  count_sum;

  assign n         = (amount == 5'd0) ? 6'd32 : {1'b0, amount};  // Zero means a full word
  assign keep_mask = ~(32'hffff_ffff << n);
  assign right_cat = {din, value} >> n;                          // New bits enter at the top
  assign shifted   = shift_right ? right_cat[31:0] : ((value << n) | (din & keep_mask));
  assign count_sum = {1'b0, count} + {1'b0, n};

  always_ff @(posedge clk) begin
    if (reset) begin
      value <= '0;
      count <= '0;
    end else if (set) begin
      value <= din;
      count <= '0;
    end else if (shift) begin
      value <= shifted;
      count <= (count_sum > 7'd32) ? 6'd32 : count_sum[5:0];   // Saturate at a full word
    end
  end

endmodule

// File: source/out_shift_reg.sv
// ----------------------------------------------------------
// Output shift register with saturating bit counter
// and the combinational view of the bits shifted out
// ----------------------------------------------------------
`timescale 1ns/100ps

module out_shift_reg (
  input  logic        clk,
  input  logic        reset,
  input  logic        shift_right,
  input  logic        set,
  input  logic        shift,
  input  logic [4:0]  amount,
  input  logic [31:0] din,
  output logic [31:0] value,
  output logic [5:0]  count,
  output logic [31:0] shifted_out
);

  logic [5:0]  n;
  logic [31:0] keep_mask;
  logic [63:0] left_cat;
  logic [31:0] remaining;
  logic [6:0]  count_sum;

  assign n         = (amount == 5'd0) ? 6'd32 : {1'b0, amount};
  assign keep_mask = ~(32'hffff_ffff << n);
  assign left_cat  = {32'b0, value} << n;                        // Top bits leave to the upper half

  // Leaving bits are right-aligned and zero padded
  assign shifted_out = shift_right ? (value & keep_mask) : left_cat[63:32];
  assign remaining   = shift_right ? (value >> n) : left_cat[31:0];
  assign count_sum   = {1'b0, count} + {1'b0, n};

  always_ff @(posedge clk) begin
    if (reset) begin
      value <= '0;
      count <= '0;
    end else if (set) begin
      value <= din;                                              // PULL or MOV to OSR
      count <= '0;
    end else if (shift) begin
      value <= remaining;
      count <= (count_sum > 7'd32) ? 6'd32 : count_sum[5:0];
    end
  end

endmodule

// File: source/pio_cfg_pkg.sv
// ----------------------------------------------------------
// Machine configuration and FIFO word types
// ----------------------------------------------------------
package pio_cfg_pkg;

  typedef struct packed {
    logic [4:0] wrap_target;
    logic [4:0] wrap_top;
    logic [4:0] out_base;
    logic [5:0] out_count;                      // Up to 32 pins
    logic [4:0] set_base;
    logic [2:0] set_count;
    logic [4:0] in_base;
    logic [4:0] jmp_pin;
    logic       in_shift_right;
    logic       out_shift_right;
  } sm_config_t;

  typedef struct packed {
    logic                               valid;
    logic [pio_isa_pkg::WORD_W-1:0]     data;
  } fifo_word_t;

endpackage

// File: source/pio_exec_unit.sv
// ----------------------------------------------------------
// Instruction decode and execute, PC with wrap, X and Y
// scratch registers, output pin and direction registers
// ----------------------------------------------------------
`timescale 1ns/100ps

module pio_exec_unit (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           en,
  input  pio_isa_pkg::instr_t            instr,
  input  pio_cfg_pkg::sm_config_t        cfg,
  input  logic [pio_isa_pkg::WORD_W-1:0] input_pins,
  input  logic [pio_isa_pkg::WORD_W-1:0] isr_value,
  input  logic [5:0]                     isr_count,
  input  logic [pio_isa_pkg::WORD_W-1:0] osr_value,
  input  logic [5:0]                     osr_count,
  input  logic [pio_isa_pkg::WORD_W-1:0] osr_out,
  input  logic [pio_isa_pkg::WORD_W-1:0] tx_word,
  input  logic                           tx_avail,
  input  logic                           rx_room,
  output logic [pio_isa_pkg::ADDR_W-1:0] pc,
  output logic [pio_isa_pkg::WORD_W-1:0] output_pins,
  output logic [pio_isa_pkg::WORD_W-1:0] pin_directions,
  output logic                           stalled,
  output logic                           isr_set,
  output logic                           isr_shift,
  output logic [pio_isa_pkg::WORD_W-1:0] isr_din,
  output logic                           osr_set,
  output logic                           osr_shift,
  output logic [pio_isa_pkg::WORD_W-1:0] osr_din,
  output logic [4:0]                     shift_amount,
  output logic                           tx_take,
  output logic                           push,
  output logic [pio_isa_pkg::WORD_W-1:0] push_word
);
  import pio_isa_pkg::*;

  localparam logic [5:0] FULL_COUNT = 6'd32;

  op_t                 op;
  jmp_cond_t           cond;
  dst_t                dst;
  src_t                src;
  bitop_t              mov_op;
  logic [WORD_W-1:0]   x;
  logic [WORD_W-1:0]   y;
  logic [2*WORD_W-1:0] pins_cat;
  logic [WORD_W-1:0]   in_pins;
  logic [WORD_W-1:0]   operand;
  logic [WORD_W-1:0]   dst_value;
  logic [4:0]          win_base;
  logic [5:0]          win_count;
  logic [WORD_W-1:0]   x_d;
  logic [WORD_W-1:0]   y_d;
  logic [WORD_W-1:0]   pins_d;
  logic [WORD_W-1:0]   dirs_d;
  logic [ADDR_W-1:0]   jump_addr;
  logic                jump;
  logic                stall;
  logic                active;
  logic                write_dst;
  logic                isr_set_req;
  logic                isr_shift_req;
  logic                osr_set_req;
  logic                osr_shift_req;
  logic                take_req;
  logic                push_req;

  // Merge val into cur over count pins from base, wrapping past pin 31
  function automatic logic [WORD_W-1:0] window(input logic [WORD_W-1:0] cur,
                                               input logic [WORD_W-1:0] val,
                                               input logic [4:0]        base,
                                               input logic [5:0]        count);
    logic [WORD_W-1:0]   mask;
    logic [2*WORD_W-1:0] mask_rot;
    logic [2*WORD_W-1:0] val_rot;
    mask     = ~({WORD_W{1'b1}} << count);
    mask_rot = {mask, mask} << base;
    val_rot  = {val, val} << base;
    return (cur & ~mask_rot[2*WORD_W-1:WORD_W]) |
           (val_rot[2*WORD_W-1:WORD_W] & mask_rot[2*WORD_W-1:WORD_W]);
  endfunction

  function automatic logic [WORD_W-1:0] apply_bitop(input bitop_t bop,
                                                    input logic [WORD_W-1:0] v);
    logic [WORD_W-1:0] r;
    case (bop)
      BITOP_INVERT:  r = ~v;
      BITOP_REVERSE: r = {<<{v}};
      default:       r = v;                                      // Reserved code acts as none
    endcase
    return r;
  endfunction

  assign op       = op_t'(instr.op);
  assign cond     = jmp_cond_t'(instr.op1);
  assign dst      = dst_t'(instr.op1);
  assign src      = src_t'((op == OP_MOV) ? instr.op2[2:0] : instr.op1);  // MOV source is in op2
  assign mov_op   = bitop_t'(instr.op2[4:3]);
  assign pins_cat = {input_pins, input_pins} >> cfg.in_base;     // Pin in_base lands on bit 0
  assign in_pins  = pins_cat[WORD_W-1:0];

  assign win_base  = (op == OP_SET) ? cfg.set_base : cfg.out_base;
  assign win_count = (op == OP_SET) ? {3'b000, cfg.set_count} : cfg.out_count;

  always_comb begin
    case (src)
      SRC_PINS: operand = in_pins;
      SRC_X:    operand = x;
      SRC_Y:    operand = y;
      SRC_ISR:  operand = isr_value;
      SRC_OSR:  operand = osr_value;
      default:  operand = '0;                                    // NULL and reserved codes
    endcase
    case (op)
      OP_OUT:  dst_value = osr_out;
      OP_SET:  dst_value = {{(WORD_W - 5){1'b0}}, instr.op2};
      default: dst_value = apply_bitop(mov_op, operand);
    endcase
  end

  always_comb begin
    stall         = 1'b0;
    jump          = 1'b0;
    jump_addr     = instr.op2;
    write_dst     = 1'b0;
    x_d           = x;
    y_d           = y;
    pins_d        = output_pins;
    dirs_d        = pin_directions;
    isr_set_req   = 1'b0;
    isr_shift_req = 1'b0;
    osr_set_req   = 1'b0;
    osr_shift_req = 1'b0;
    take_req      = 1'b0;
    push_req      = 1'b0;
    isr_din       = operand;
    osr_din       = dst_value;
    case (op)
      OP_JMP: begin
        case (cond)
          COND_ALWAYS:        jump = 1'b1;
          COND_X_ZERO:        jump = (x == '0);
          COND_X_DEC: begin
            jump = (x != '0);
            if (x != '0) x_d = x - 1'b1;                         // Decrement only when nonzero
          end
          COND_Y_ZERO:        jump = (y == '0);
          COND_Y_DEC: begin
            jump = (y != '0);
            if (y != '0) y_d = y - 1'b1;
          end
          COND_X_NE_Y:        jump = (x != y);
          COND_PIN:           jump = input_pins[cfg.jmp_pin];
          COND_OSR_NOT_EMPTY: jump = (osr_count < FULL_COUNT);
        endcase
      end
      OP_WAIT: begin
        case (instr.op1[1:0])
          2'd0:    stall = (input_pins[instr.op2] != instr.op1[2]);
          2'd1:    stall = (input_pins[cfg.in_base + instr.op2] != instr.op1[2]);
          default: stall = 1'b0;                                 // IRQ wait unsupported
        endcase
      end
      OP_IN:  isr_shift_req = 1'b1;
      OP_OUT: begin
        osr_shift_req = 1'b1;                                    // Other destinations discard bits
        write_dst     = 1'b1;
      end
      OP_PUSHPULL: begin
        if (!instr.op1[2]) begin
          if (!instr.op1[1] || isr_count == FULL_COUNT) begin
            if (rx_room) begin
              push_req    = 1'b1;
              isr_set_req = 1'b1;
              isr_din     = '0;
            end else begin
              stall = instr.op1[0];                              // Blocking waits for a credit
            end
          end
        end else if (!instr.op1[1] || osr_count == FULL_COUNT) begin
          if (tx_avail) begin
            take_req    = 1'b1;
            osr_set_req = 1'b1;
            osr_din     = tx_word;
          end else if (instr.op1[0]) begin
            stall = 1'b1;
          end else begin
            osr_set_req = 1'b1;                                  // Empty nonblocking PULL copies X
            osr_din     = x;
          end
        end
      end
      OP_MOV, OP_SET: write_dst = 1'b1;
      default: ;                                                 // IRQ runs as a no-op
    endcase

    if (write_dst) begin
      case (dst)
        DST_PINS:    pins_d = window(output_pins, dst_value, win_base, win_count);
        DST_X:       x_d = dst_value;
        DST_Y:       y_d = dst_value;
        DST_PINDIRS: dirs_d = window(pin_directions, dst_value, win_base, win_count);
        DST_PC: begin
          jump      = (op != OP_SET);
          jump_addr = dst_value[ADDR_W-1:0];
        end
        DST_ISR: begin
          isr_set_req = (op == OP_MOV);
          isr_din     = dst_value;
        end
        DST_OSR:     osr_set_req = (op == OP_MOV);
        default: ;
      endcase
    end
  end

  assign active       = en && !stall;
  assign isr_set      = active && isr_set_req;
  assign isr_shift    = active && isr_shift_req;
  assign osr_set      = active && osr_set_req;
  assign osr_shift    = active && osr_shift_req;
  assign tx_take      = active && take_req;
  assign push         = active && push_req;
  assign push_word    = isr_value;
  assign shift_amount = instr.op2;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc             <= '0;
      x              <= '0;
      y              <= '0;
      output_pins    <= '0;
      pin_directions <= '0;
      stalled        <= 1'b0;
    end else begin
      stalled <= en && stall;
      if (active) begin
        if (jump) pc <= jump_addr;
        else if (pc == cfg.wrap_top) pc <= cfg.wrap_target;      // Program wrap
        else pc <= pc + 1'b1;
        x              <= x_d;
        y              <= y_d;
        output_pins    <= pins_d;
        pin_directions <= dirs_d;
      end
    end
  end

endmodule

// File: source/pio_isa_pkg.sv
// ----------------------------------------------------------
// Instruction set definitions for the PIO state machine
// Opcode, condition, operand and bit-operation enums
// ----------------------------------------------------------
package pio_isa_pkg;

  localparam int WORD_W = 32;                   // Data word and pin bank width
  localparam int ADDR_W = 5;                    // Program address width

  typedef enum logic [2:0] {
    OP_JMP, OP_WAIT, OP_IN, OP_OUT, OP_PUSHPULL, OP_MOV, OP_IRQ, OP_SET
  } op_t;

  typedef enum logic [2:0] {
    COND_ALWAYS, COND_X_ZERO, COND_X_DEC, COND_Y_ZERO,
    COND_Y_DEC, COND_X_NE_Y, COND_PIN, COND_OSR_NOT_EMPTY
  } jmp_cond_t;

  typedef enum logic [2:0] {
    SRC_PINS = 3'd0, SRC_X = 3'd1, SRC_Y = 3'd2, SRC_NULL = 3'd3,
    SRC_ISR = 3'd6, SRC_OSR = 3'd7
  } src_t;

  typedef enum logic [2:0] {
    DST_PINS = 3'd0, DST_X = 3'd1, DST_Y = 3'd2, DST_PINDIRS = 3'd4,
    DST_PC = 3'd5, DST_ISR = 3'd6, DST_OSR = 3'd7
  } dst_t;

  typedef enum logic [1:0] {
    BITOP_NONE, BITOP_INVERT, BITOP_REVERSE
  } bitop_t;

  typedef struct packed {
    logic [2:0] op;
    logic [4:0] delay;                          // Not used by this machine
    logic [2:0] op1;
    logic [4:0] op2;
  } instr_t;

endpackage

// File: source/pio_machine.sv
// ----------------------------------------------------------
// PIO state machine top level
// Execute unit, shift registers and credit-based FIFO ports
// ----------------------------------------------------------
`timescale 1ns/100ps

module pio_machine #(
  parameter int TX_DEPTH   = 4,
  parameter int RX_CREDITS = 4
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           en,
  input  pio_isa_pkg::instr_t            instr,
  input  pio_cfg_pkg::sm_config_t        cfg,
  input  logic [pio_isa_pkg::WORD_W-1:0] input_pins,
  input  pio_cfg_pkg::fifo_word_t        tx,
  input  logic                           rx_credit,
  output logic [pio_isa_pkg::ADDR_W-1:0] pc,
  output logic [pio_isa_pkg::WORD_W-1:0] output_pins,
  output logic [pio_isa_pkg::WORD_W-1:0] pin_directions,
  output logic                           tx_credit,
  output pio_cfg_pkg::fifo_word_t        rx,
  output logic                           stalled
);
  import pio_isa_pkg::*;

  logic [WORD_W-1:0] isr_value;
  logic [WORD_W-1:0] osr_value;
  logic [WORD_W-1:0] osr_out;
  logic [WORD_W-1:0] isr_din;
  logic [WORD_W-1:0] osr_din;
  logic [WORD_W-1:0] tx_word;
  logic [WORD_W-1:0] push_word;
  logic [5:0]        isr_count;
  logic [5:0]        osr_count;
  logic [4:0]        shift_amount;
  logic              isr_set;
  logic              isr_shift;
  logic              osr_set;
  logic              osr_shift;
  logic              tx_take;
  logic              tx_avail;
  logic              push;
  logic              rx_room;

  pio_exec_unit pio_exec_unit_inst (
    .clk            (clk),
    .reset          (reset),
    .en             (en),
    .instr          (instr),
    .cfg            (cfg),
    .input_pins     (input_pins),
    .isr_value      (isr_value),
    .isr_count      (isr_count),
    .osr_value      (osr_value),
    .osr_count      (osr_count),
    .osr_out        (osr_out),
    .tx_word        (tx_word),
    .tx_avail       (tx_avail),
    .rx_room        (rx_room),
    .pc             (pc),
    .output_pins    (output_pins),
    .pin_directions (pin_directions),
    .stalled        (stalled),
    .isr_set        (isr_set),
    .isr_shift      (isr_shift),
    .isr_din        (isr_din),
    .osr_set        (osr_set),
    .osr_shift      (osr_shift),
    .osr_din        (osr_din),
    .shift_amount   (shift_amount),
    .tx_take        (tx_take),
    .push           (push),
    .push_word      (push_word)
  );

  in_shift_reg in_shift_reg_inst (
    .clk         (clk),
    .reset       (reset),
    .shift_right (cfg.in_shift_right),
    .set         (isr_set),
    .shift       (isr_shift),
    .amount      (shift_amount),
    .din         (isr_din),
    .value       (isr_value),
    .count       (isr_count)
  );

  out_shift_reg out_shift_reg_inst (
    .clk         (clk),
    .reset       (reset),
    .shift_right (cfg.out_shift_right),
    .set         (osr_set),
    .shift       (osr_shift),
    .amount      (shift_amount),
    .din         (osr_din),
    .value       (osr_value),
    .count       (osr_count),
    .shifted_out (osr_out)
  );

  tx_credit_buffer #(
    .TX_DEPTH (TX_DEPTH)
  ) tx_credit_buffer_inst (
    .clk    (clk),
    .reset  (reset),
    .tx     (tx),
    .take   (tx_take),
    .word   (tx_word),
    .avail  (tx_avail),
    .credit (tx_credit)
  );

  rx_credit_port #(
    .RX_CREDITS (RX_CREDITS)
  ) rx_credit_port_inst (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .word      (push_word),
    .rx_credit (rx_credit),
    .rx        (rx),
    .room      (rx_room)
  );

endmodule

// File: source/rx_credit_port.sv
// ----------------------------------------------------------
// RX credit counter and registered output word
// ----------------------------------------------------------
`timescale 1ns/100ps

module rx_credit_port #(
  parameter int RX_CREDITS = 4
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           push,
  input  logic [pio_isa_pkg::WORD_W-1:0] word,
  input  logic                           rx_credit,
  output pio_cfg_pkg::fifo_word_t        rx,
  output logic                           room
);

  localparam int CNT_W = $clog2(RX_CREDITS + 1);

  logic [CNT_W-1:0] credits;

  assign room = (credits != '0);

  always_ff @(posedge clk) begin
    if (push) rx.data <= word;
    if (reset) begin
      credits  <= CNT_W'(RX_CREDITS);
      rx.valid <= 1'b0;
    end else begin
      credits  <= credits + CNT_W'(rx_credit) - CNT_W'(push);   // Return and spend in one cycle
      rx.valid <= push;                                          // Single cycle word strobe
    end
  end

endmodule

// File: source/tx_credit_buffer.sv
// ----------------------------------------------------------
// TX receive buffer that returns one credit per word taken
// ----------------------------------------------------------
`timescale 1ns/100ps

module tx_credit_buffer #(
  parameter int TX_DEPTH = 4
) (
  input  logic                           clk,
  input  logic                           reset,
  input  pio_cfg_pkg::fifo_word_t        tx,
  input  logic                           take,
  output logic [pio_isa_pkg::WORD_W-1:0] word,
  output logic                           avail,
  output logic                           credit
);
  import pio_isa_pkg::*;

  localparam int PTR_W = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;

  logic [WORD_W-1:0] mem [TX_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    level;                                      // Words held

  function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(TX_DEPTH - 1)) ? '0 : p + 1'b1;          // Circular wrap
  endfunction

  assign word  = mem[rd_ptr];
  assign avail = (level != '0);

  always_ff @(posedge clk) begin
    if (tx.valid) mem[wr_ptr] <= tx.data;                        // Credits keep this from overflowing
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
      credit <= 1'b0;
    end else begin
      credit <= take;                                            // One credit back per removal
      if (tx.valid) wr_ptr <= bump(wr_ptr);
      if (take) rd_ptr <= bump(rd_ptr);
      level <= level + (PTR_W + 1)'(tx.valid) - (PTR_W + 1)'(take);
    end
  end

endmodule

// File: test/pio_machine_tb.sv
// ----------------------------------------------------------
// Testbench for the PIO state machine with random programs,
// TX and RX credit traffic, cycle model and output checks
// ----------------------------------------------------------
`timescale 1ns/100ps

module pio_machine_tb;
  import pio_isa_pkg::*;
  import pio_cfg_pkg::*;

  localparam int TX_DEPTH     = 4;
  localparam int RX_CREDITS   = 4;
  localparam int RESET_CYCLES = 3;
  localparam int NUM_CYCLES   = 4000;
  localparam int PHASE_LEN    = 500;                 // New program and config every phase

  logic        clk;
  logic        reset;
  logic        en;
  instr_t      instr;
  sm_config_t  cfg;
  logic [31:0] input_pins;
  fifo_word_t  tx;
  logic        rx_credit;
  logic [4:0]  pc;
  logic [31:0] output_pins;
  logic [31:0] pin_directions;
  logic        tx_credit;
  fifo_word_t  rx;
  logic        stalled;

  logic [15:0] prog [32];
  logic [31:0] rng;
  int          cycle;
  int          send_rate;
  int          ret_rate;
  int          prod_credits;                       // Producer side TX credits
  int          owed_credits;                       // RX credits the consumer still has to return
  bit          checking;

  // Model state
  logic [4:0]  m_pc;
  logic [31:0] m_x;
  logic [31:0] m_y;
  logic [31:0] m_pins;
  logic [31:0] m_dirs;
  logic [31:0] m_isr;
  logic [31:0] m_osr;
  int          m_isr_cnt;
  int          m_osr_cnt;
  logic [31:0] tx_q [$];
  int          rx_room_cnt;
  logic        m_rx_valid;
  logic [31:0] m_rx_data;
  logic        m_tx_credit;
  logic        m_stalled;

  assign instr = prog[pc];                         // Program memory outside the DUT

  initial clk = 1'b0;
  always #5 clk = ~clk;

  pio_machine #(
    .TX_DEPTH   (TX_DEPTH),
    .RX_CREDITS (RX_CREDITS)
  ) pio_machine_inst (
    .clk            (clk),
    .reset          (reset),
    .en             (en),
    .instr          (instr),
    .cfg            (cfg),
    .input_pins     (input_pins),
    .tx             (tx),
    .rx_credit      (rx_credit),
    .pc             (pc),
    .output_pins    (output_pins),
    .pin_directions (pin_directions),
    .tx_credit      (tx_credit),
    .rx             (rx),
    .stalled        (stalled)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [31:0] next_random();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [31:0] low_mask(input int n);
    logic [63:0] m;
    m = (64'd1 << n) - 64'd1;
    return m[31:0];
  endfunction

  function automatic logic [31:0] reverse_bits(input logic [31:0] v);
    logic [31:0] r;
    for (int i = 0; i < 32; i++) r[i] = v[31 - i];
    return r;
  endfunction

  // Pin base lands on bit 0, wrapping past pin 31
  function automatic logic [31:0] pins_from_base(input logic [31:0] p, input int base);
    logic [31:0] r;
    for (int i = 0; i < 32; i++) r[i] = p[(i + base) % 32];
    return r;
  endfunction

  function automatic logic [31:0] merge_window(input logic [31:0] cur, input logic [31:0] val,
                                               input int base, input int count);
    logic [31:0] r;
    r = cur;
    for (int i = 0; i < 32; i++) begin
      if (i < count) r[(base + i) % 32] = val[i];
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Finished with errors");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic new_program();
    sm_config_t  c;
    logic [31:0] r;
    r = next_random();
    c.wrap_target     = r[4:0];
    c.wrap_top        = r[9:5];
    c.out_base        = r[14:10];
    c.out_count       = r[20:15];
    c.set_base        = r[25:21];
    c.set_count       = r[28:26];
    c.in_shift_right  = r[29];
    c.out_shift_right = r[30];
    r = next_random();
    c.in_base = r[4:0];
    c.jmp_pin = r[9:5];
    send_rate = 1 + int'(r[12:10]);                // Out of 8
    ret_rate  = 1 + int'(r[16:13]);                // Low rates out of 16 starve RX
    cfg <= c;
    for (int i = 0; i < 32; i++) begin
      r = next_random();
      prog[i] <= r[15:0];
    end
  endtask

  task automatic step_model();
    logic [15:0] ins;
    logic [2:0]  op;
    logic [2:0]  op1;
    logic [4:0]  op2;
    logic [2:0]  src;
    logic [31:0] operand;
    logic [31:0] value;
    logic [31:0] data;
    logic [4:0]  target;
    logic [31:0] nx;
    logic [31:0] ny;
    logic [31:0] npins;
    logic [31:0] ndirs;
    logic [31:0] nisr;
    logic [31:0] nosr;
    int          nisr_cnt;
    int          nosr_cnt;
    int          n;
    int          wbase;
    int          wcount;
    logic        stall;
    logic        jump;
    logic        take;
    logic        push;
    logic        active;
    ins      = prog[m_pc];
    op       = ins[15:13];
    op1      = ins[7:5];
    op2      = ins[4:0];
    n        = (op2 == 5'd0) ? 32 : int'(op2);
    src      = (op == OP_MOV) ? op2[2:0] : op1;
    {stall, jump, take, push} = 4'b0000;
    target   = op2;
    {nx, ny, npins, ndirs} = {m_x, m_y, m_pins, m_dirs};
    {nisr, nosr} = {m_isr, m_osr};
    nisr_cnt = m_isr_cnt;
    nosr_cnt = m_osr_cnt;
    case (src)
      3'd0:    operand = pins_from_base(input_pins, int'(cfg.in_base));
      3'd1:    operand = m_x;
      3'd2:    operand = m_y;
      3'd6:    operand = m_isr;
      3'd7:    operand = m_osr;
      default: operand = '0;
    endcase
    if (op2[4:3] == 2'd1) value = ~operand;
    else if (op2[4:3] == 2'd2) value = reverse_bits(operand);
    else value = operand;

    case (op)
      OP_JMP: begin
        case (op1)
          COND_ALWAYS: jump = 1'b1;
          COND_X_ZERO: jump = (m_x == 0);
          COND_X_DEC: begin
            jump = (m_x != 0);
            if (jump) nx = m_x - 1;
          end
          COND_Y_ZERO: jump = (m_y == 0);
          COND_Y_DEC: begin
            jump = (m_y != 0);
            if (jump) ny = m_y - 1;
          end
          COND_X_NE_Y: jump = (m_x != m_y);
          COND_PIN:    jump = input_pins[cfg.jmp_pin];
          default:     jump = (m_osr_cnt < 32);    // OSR not yet fully shifted
        endcase
      end
      OP_WAIT: begin
        if (op1[1:0] == 2'd0) stall = (input_pins[op2] != op1[2]);
        else if (op1[1:0] == 2'd1)
          stall = (input_pins[(int'(cfg.in_base) + int'(op2)) % 32] != op1[2]);
      end
      OP_IN: begin
        data = operand & low_mask(n);
        if (n == 32) nisr = data;
        else if (cfg.in_shift_right) nisr = (m_isr >> n) | (data << (32 - n));
        else nisr = (m_isr << n) | data;
        nisr_cnt = (m_isr_cnt + n > 32) ? 32 : m_isr_cnt + n;
      end
      OP_OUT: begin
        if (cfg.out_shift_right) value = m_osr & low_mask(n);
        else value = m_osr >> (32 - n);
        if (n == 32) nosr = '0;
        else if (cfg.out_shift_right) nosr = m_osr >> n;
        else nosr = m_osr << n;
        nosr_cnt = (m_osr_cnt + n > 32) ? 32 : m_osr_cnt + n;
      end
      OP_PUSHPULL: begin
        if (!op1[2]) begin
          if (!op1[1] || m_isr_cnt == 32) begin
            if (rx_room_cnt > 0) begin
              push     = 1'b1;
              nisr     = '0;
              nisr_cnt = 0;
            end else begin
              stall = op1[0];
            end
          end
        end else if (!op1[1] || m_osr_cnt == 32) begin
          if (tx_q.size() > 0) begin
            take     = 1'b1;
            nosr     = tx_q[0];
            nosr_cnt = 0;
          end else if (op1[0]) begin
            stall = 1'b1;
          end else begin
            nosr     = m_x;                        // Empty buffer falls back to X
            nosr_cnt = 0;
          end
        end
      end
      OP_SET: value = {27'd0, op2};
      default: ;
    endcase

    if (op == OP_OUT || op == OP_MOV || op == OP_SET) begin
      wbase  = (op == OP_SET) ? int'(cfg.set_base) : int'(cfg.out_base);
      wcount = (op == OP_SET) ? int'(cfg.set_count) : int'(cfg.out_count);
      case (op1)
        DST_PINS:    npins = merge_window(m_pins, value, wbase, wcount);
        DST_X:       nx = value;
        DST_Y:       ny = value;
        DST_PINDIRS: ndirs = merge_window(m_dirs, value, wbase, wcount);
        DST_PC: begin
          jump   = (op != OP_SET);
          target = value[4:0];
        end
        DST_ISR: begin
          if (op == OP_MOV) nisr = value;
          if (op == OP_MOV) nisr_cnt = 0;
        end
        DST_OSR: begin
          if (op == OP_MOV) nosr = value;
          if (op == OP_MOV) nosr_cnt = 0;
        end
        default: ;
      endcase
    end

    active = en && !stall;
    if (active && push) m_rx_data = m_isr;        // Word leaves before the ISR clears
    if (active) begin
      if (jump) m_pc = target;
      else if (m_pc == cfg.wrap_top) m_pc = cfg.wrap_target;
      else m_pc = m_pc + 1'b1;
      {m_x, m_y, m_pins, m_dirs} = {nx, ny, npins, ndirs};
      {m_isr, m_osr} = {nisr, nosr};
      m_isr_cnt = nisr_cnt;
      m_osr_cnt = nosr_cnt;
      if (take) void'(tx_q.pop_front());
    end
    m_rx_valid  = active && push;
    m_tx_credit = active && take;
    m_stalled   = en && stall;
    rx_room_cnt = rx_room_cnt + int'(rx_credit) - int'(m_rx_valid);
    if (tx.valid) tx_q.push_back(tx.data);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      {m_pc, m_x, m_y, m_pins, m_dirs, m_isr, m_osr} = '0;
      {m_rx_valid, m_tx_credit, m_stalled} = 3'b000;
      m_isr_cnt    = 0;
      m_osr_cnt    = 0;
      rx_room_cnt  = RX_CREDITS;
      prod_credits = TX_DEPTH;
      owed_credits = 0;
      checking     = 1'b1;
      tx_q.delete();
    end else begin
      prod_credits = prod_credits - int'(tx.valid) + int'(tx_credit);
      owed_credits = owed_credits + int'(rx.valid) - int'(rx_credit);
      step_model();
      check_value("TX words in flight within depth", tx_q.size() <= TX_DEPTH, 1);
    end

    cycle++;
    if (cycle % PHASE_LEN == 0) new_program();
    en         <= (next_random() % 16) != 0;
    input_pins <= next_random();
    if (prod_credits > 0 && (next_random() % 8) < send_rate) begin
      tx.valid <= 1'b1;                            // Only sent while holding a credit
      tx.data  <= next_random();
    end else begin
      tx.valid <= 1'b0;
    end
    rx_credit <= (owed_credits > 0) && ((next_random() % 16) < ret_rate);
  end

  always @(negedge clk) begin
    if (checking) begin
      check_value("pc", pc, m_pc);
      check_value("output_pins", output_pins, m_pins);
      check_value("pin_directions", pin_directions, m_dirs);
      check_value("rx.valid", rx.valid, m_rx_valid);
      if (m_rx_valid) check_value("rx.data", rx.data, m_rx_data);
      check_value("tx_credit", tx_credit, m_tx_credit);
      check_value("stalled", stalled, m_stalled);
    end
  end

  initial begin
    #((NUM_CYCLES + RESET_CYCLES) * 10 + 2000);
    $display("Timeout: the run did not reach its last cycle in time");
    $display("Finished with errors");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    reset      = 1'b1;
    en         = 1'b0;
    input_pins = '0;
    tx         = '0;
    rx_credit  = 1'b0;
    rng        = 32'd182;
    cycle      = 0;
    checking   = 1'b0;
    new_program();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    repeat (NUM_CYCLES) @(posedge clk);
    @(negedge clk);
    #1;
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: verilog.f
source/pio_isa_pkg.sv
source/pio_cfg_pkg.sv
source/in_shift_reg.sv
source/out_shift_reg.sv
source/tx_credit_buffer.sv
source/rx_credit_port.sv
source/pio_exec_unit.sv
source/pio_machine.sv
test/pio_machine_tb.sv
